/* cpu_pkg.sv */
package cpu_pkg;

    // RV32 major opcodes in use
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5
    } alu_func_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_IMM = 2'd2,
        WB_PC4 = 2'd3
    } wbsel_e;

    // Second ALU operand
    typedef enum logic {
        OP_REG = 1'b0,
        OP_IMM = 1'b1
    } opsel_e;

    // funct3 / funct7 codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam int unsigned DMEM_AW = 6;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* fetch.sv */
`timescale 1ns/1ps

module fetch import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  logic        redirect_i,
    input  logic [31:0] br_target_i,
    input  logic [31:0] instr_if_i,
    output logic [31:0] pc_if_o,
    output logic [31:0] pc_id_o,
    output logic [31:0] instr_id_o
);

    // Stall wins over a redirect, which decode raises again next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_if_o <= RESET_PC;
        end else if (!stall_i) begin
            pc_if_o <= redirect_i ? br_target_i : pc_if_o + 32'd4;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (reset_i || (flush_i && !stall_i)) begin
            instr_id_o <= NOP_INSTR;
        end else if (!stall_i) begin
            instr_id_o <= instr_if_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_id_o <= pc_if_o;
        end
    end

endmodule

/* decode.sv */
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        stall_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] rs2_data_i,
    output logic [4:0]  rs1_addr_o,
    output logic [4:0]  rs2_addr_o,
    output logic        rs1_used_o,
    output logic        rs2_used_o,
    output logic        redirect_o,
    output logic [31:0] br_target_o,
    output logic [31:0] pc_o,
    output alu_func_e   alu_func_o,
    output opsel_e      opsel_o,
    output wbsel_e      wbsel_o,
    output logic [31:0] rs1_value_o,
    output logic [31:0] rs2_value_o,
    output logic [31:0] imm_o,
    output logic [4:0]  rd_addr_o,
    output logic        rf_w_en_o,
    output logic        mem_w_en_o
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i_type;
    logic [31:0] imm_s_type;
    logic [31:0] imm_b_type;
    logic [31:0] imm_u_type;
    logic [31:0] imm_j_type;
    alu_func_e   alu_func;
    opsel_e      opsel;
    wbsel_e      wbsel;
    logic [31:0] imm;
    logic        rf_w_en;
    logic        mem_w_en;
    logic        is_branch;
    logic        is_jal;
    logic        rs_equal;
    logic        taken;

    assign opcode     = opcode_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        alu_func   = ALU_ADD;
        opsel      = OP_REG;
        wbsel      = WB_ALU;
        imm        = imm_i_type;
        rf_w_en    = 1'b0;
        mem_w_en   = 1'b0;
        rs1_used_o = 1'b0;
        rs2_used_o = 1'b0;
        is_branch  = 1'b0;
        is_jal     = 1'b0;
        case (opcode)
            OPC_OP: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                rf_w_en    = 1'b1;
                case (funct3)
                    F3_ADD:  alu_func = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:  alu_func = ALU_SLT;
                    F3_XOR:  alu_func = ALU_XOR;
                    F3_OR:   alu_func = ALU_OR;
                    F3_AND:  alu_func = ALU_AND;
                    default: rf_w_en  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                rs1_used_o = 1'b1;
                opsel      = OP_IMM;
                rf_w_en    = (funct3 == F3_ADD);
            end
            OPC_LUI: begin
                wbsel   = WB_IMM;
                imm     = imm_u_type;
                rf_w_en = 1'b1;
            end
            OPC_LOAD: begin
                rs1_used_o = 1'b1;
                opsel      = OP_IMM;
                wbsel      = WB_MEM;
                rf_w_en    = (funct3 == F3_LW);
            end
            OPC_STORE: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                opsel      = OP_IMM;
                imm        = imm_s_type;
                mem_w_en   = (funct3 == F3_SW);
            end
            OPC_BRANCH: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                imm        = imm_b_type;
                is_branch  = 1'b1;
            end
            OPC_JAL: begin
                imm     = imm_j_type;
                wbsel   = WB_PC4;
                rf_w_en = 1'b1;
                is_jal  = 1'b1;
            end
            default: ;
        endcase
    end

    // Branch resolution in ID
    assign rs_equal    = (rs1_data_i == rs2_data_i);
    assign taken       = is_branch && (((funct3 == F3_BEQ) && rs_equal) ||
                                       ((funct3 == F3_BNE) && !rs_equal));
    assign redirect_o  = is_jal || taken;
    assign br_target_o = pc_i + imm;

    // ID/EX, bubble on stall
    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            rf_w_en_o  <= 1'b0;
            mem_w_en_o <= 1'b0;
        end else begin
            rf_w_en_o  <= rf_w_en;
            mem_w_en_o <= mem_w_en;
        end
    end

    always_ff @(posedge clk) begin
        pc_o        <= pc_i;
        alu_func_o  <= alu_func;
        opsel_o     <= opsel;
        wbsel_o     <= wbsel;
        rs1_value_o <= rs1_data_i;
        rs2_value_o <= rs2_data_i;
        imm_o       <= imm;
        rd_addr_o   <= instr_i[11:7];
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        w_en_i,
    input  logic [4:0]  ra_addr_i,
    input  logic [4:0]  rb_addr_i,
    input  logic [4:0]  rd_addr_i,
    input  logic [31:0] w_data_i,
    output logic [31:0] ra_value_o,
    output logic [31:0] rb_value_o
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en_i && (rd_addr_i != 5'd0)) begin
            regs[rd_addr_i] <= w_data_i;
        end
    end

    // x0 reads zero, a write in flight reads through
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (w_en_i && (addr == rd_addr_i)) begin
            return w_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        ra_value_o = read_port(ra_addr_i);
    end

    always_comb begin
        rb_value_o = read_port(rb_addr_i);
    end

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [31:0] pc_i,
    input  alu_func_e   alu_func_i,
    input  opsel_e      opsel_i,
    input  wbsel_e      wbsel_i,
    input  logic [31:0] rs1_value_i,
    input  logic [31:0] rs2_value_i,
    input  logic [31:0] imm_i,
    input  logic [4:0]  rd_addr_i,
    input  logic        rf_w_en_i,
    input  logic        mem_w_en_i,
    output logic [31:0] pc_o,
    output logic [31:0] alu_out_o,
    output logic [31:0] rs2_value_o,
    output logic [31:0] imm_o,
    output logic [4:0]  rd_addr_o,
    output logic        rf_w_en_o,
    output logic        mem_w_en_o,
    output wbsel_e      wbsel_o
);

    logic [31:0] op_b;
    logic [31:0] alu_res;

    assign op_b = (opsel_i == OP_IMM) ? imm_i : rs2_value_i;

    always_comb begin
        case (alu_func_i)
            ALU_ADD: alu_res = rs1_value_i + op_b;
            ALU_SUB: alu_res = rs1_value_i - op_b;
            ALU_AND: alu_res = rs1_value_i & op_b;
            ALU_OR:  alu_res = rs1_value_i | op_b;
            ALU_XOR: alu_res = rs1_value_i ^ op_b;
            // Signed compare
            ALU_SLT: alu_res = {31'b0, $signed(rs1_value_i) < $signed(op_b)};
            default: alu_res = '0;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rf_w_en_o  <= 1'b0;
            mem_w_en_o <= 1'b0;
        end else begin
            rf_w_en_o  <= rf_w_en_i;
            mem_w_en_o <= mem_w_en_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_o        <= pc_i;
        alu_out_o   <= alu_res;
        rs2_value_o <= rs2_value_i;
        imm_o       <= imm_i;
        rd_addr_o   <= rd_addr_i;
        wbsel_o     <= wbsel_i;
    end

endmodule

/* memory_access.sv */
`timescale 1ns/1ps

module memory_access import cpu_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [31:0]        pc_i,
    input  logic [31:0]        alu_result_i,
    input  logic [31:0]        rs2_value_i,
    input  logic [31:0]        imm_i,
    input  logic [4:0]         rd_addr_i,
    input  logic               rf_w_en_i,
    input  logic               mem_w_en_i,
    input  wbsel_e             wbsel_i,
    input  logic [31:0]        dmem_rdata_i,
    output logic               dmem_w_en_o,
    output logic [DMEM_AW-1:0] dmem_addr_o,
    output logic [31:0]        dmem_wdata_o,
    output logic [4:0]         rd_addr_o,
    output logic               rf_w_en_o,
    output logic [31:0]        rf_wdata_o
);

    logic [31:0] pc_wb;
    logic [31:0] alu_result_wb;
    logic [31:0] load_data_wb;
    logic [31:0] imm_wb;
    wbsel_e      wbsel_wb;

    // Word address from the byte address
    assign dmem_w_en_o  = mem_w_en_i;
    assign dmem_addr_o  = alu_result_i[DMEM_AW+1:2];
    assign dmem_wdata_o = rs2_value_i;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rf_w_en_o <= 1'b0;
        end else begin
            rf_w_en_o <= rf_w_en_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_wb         <= pc_i;
        alu_result_wb <= alu_result_i;
        load_data_wb  <= dmem_rdata_i;
        imm_wb        <= imm_i;
        rd_addr_o     <= rd_addr_i;
        wbsel_wb      <= wbsel_i;
    end

    always_comb begin
        case (wbsel_wb)
            WB_MEM:  rf_wdata_o = load_data_wb;
            WB_IMM:  rf_wdata_o = imm_wb;
            WB_PC4:  rf_wdata_o = pc_wb + 32'd4;
            default: rf_wdata_o = alu_result_wb;
        endcase
    end

endmodule

/* hazard_detect.sv */
`timescale 1ns/1ps

module hazard_detect (
    input  logic [4:0] rs1_addr_i,
    input  logic [4:0] rs2_addr_i,
    input  logic       rs1_used_i,
    input  logic       rs2_used_i,
    input  logic [4:0] rd_ex_i,
    input  logic       rf_w_en_ex_i,
    input  logic [4:0] rd_mem_i,
    input  logic       rf_w_en_mem_i,
    input  logic       redirect_i,
    output logic       stall_o,
    output logic       flush_o
);

    logic rs1_hit;
    logic rs2_hit;

    // Source still pending in EX or MEM, WB reads through the regfile
    assign rs1_hit = rs1_used_i && (rs1_addr_i != 5'd0) &&
                     ((rf_w_en_ex_i && (rd_ex_i == rs1_addr_i)) ||
                      (rf_w_en_mem_i && (rd_mem_i == rs1_addr_i)));
    assign rs2_hit = rs2_used_i && (rs2_addr_i != 5'd0) &&
                     ((rf_w_en_ex_i && (rd_ex_i == rs2_addr_i)) ||
                      (rf_w_en_mem_i && (rd_mem_i == rs2_addr_i)));

    assign stall_o = rs1_hit || rs2_hit;

    // Stalled redirect is resolved again next cycle
    assign flush_o = redirect_i && !stall_o;

endmodule

/* cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [31:0]        instr_if_i,
    input  logic [31:0]        dmem_rdata_i,
    output logic [31:0]        pc_if_o,
    output logic               dmem_w_en_o,
    output logic [DMEM_AW-1:0] dmem_addr_o,
    output logic [31:0]        dmem_wdata_o
);

    logic [31:0] pc_id;
    logic [31:0] instr_id;
    logic        stall;
    logic        flush_if;
    logic        redirect;
    logic [31:0] br_target;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic        rs1_used;
    logic        rs2_used;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    // ID/EX
    logic [31:0] pc_ex;
    alu_func_e   alu_func_ex;
    opsel_e      opsel_ex;
    wbsel_e      wbsel_ex;
    logic [31:0] rs1_value_ex;
    logic [31:0] rs2_value_ex;
    logic [31:0] imm_ex;
    logic [4:0]  rd_addr_ex;
    logic        rf_w_en_ex;
    logic        mem_w_en_ex;

    // EX/MEM
    logic [31:0] pc_mem;
    logic [31:0] alu_out_mem;
    logic [31:0] rs2_value_mem;
    logic [31:0] imm_mem;
    logic [4:0]  rd_addr_mem;
    logic        rf_w_en_mem;
    logic        mem_w_en_mem;
    wbsel_e      wbsel_mem;

    // Writeback
    logic [4:0]  rd_addr_wb;
    logic        rf_w_en_wb;
    logic [31:0] rf_wdata_wb;

    fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stall),
        .flush_i     (flush_if),
        .redirect_i  (redirect),
        .br_target_i (br_target),
        .instr_if_i  (instr_if_i),
        .pc_if_o     (pc_if_o),
        .pc_id_o     (pc_id),
        .instr_id_o  (instr_id)
    );

    decode u_decode (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stall),
        .pc_i        (pc_id),
        .instr_i     (instr_id),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_used_o  (rs1_used),
        .rs2_used_o  (rs2_used),
        .redirect_o  (redirect),
        .br_target_o (br_target),
        .pc_o        (pc_ex),
        .alu_func_o  (alu_func_ex),
        .opsel_o     (opsel_ex),
        .wbsel_o     (wbsel_ex),
        .rs1_value_o (rs1_value_ex),
        .rs2_value_o (rs2_value_ex),
        .imm_o       (imm_ex),
        .rd_addr_o   (rd_addr_ex),
        .rf_w_en_o   (rf_w_en_ex),
        .mem_w_en_o  (mem_w_en_ex)
    );

    regfile u_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .w_en_i     (rf_w_en_wb),
        .ra_addr_i  (rs1_addr),
        .rb_addr_i  (rs2_addr),
        .rd_addr_i  (rd_addr_wb),
        .w_data_i   (rf_wdata_wb),
        .ra_value_o (rs1_data),
        .rb_value_o (rs2_data)
    );

    execute u_execute (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_ex),
        .alu_func_i  (alu_func_ex),
        .opsel_i     (opsel_ex),
        .wbsel_i     (wbsel_ex),
        .rs1_value_i (rs1_value_ex),
        .rs2_value_i (rs2_value_ex),
        .imm_i       (imm_ex),
        .rd_addr_i   (rd_addr_ex),
        .rf_w_en_i   (rf_w_en_ex),
        .mem_w_en_i  (mem_w_en_ex),
        .pc_o        (pc_mem),
        .alu_out_o   (alu_out_mem),
        .rs2_value_o (rs2_value_mem),
        .imm_o       (imm_mem),
        .rd_addr_o   (rd_addr_mem),
        .rf_w_en_o   (rf_w_en_mem),
        .mem_w_en_o  (mem_w_en_mem),
        .wbsel_o     (wbsel_mem)
    );

    memory_access u_memory_access (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_i         (pc_mem),
        .alu_result_i (alu_out_mem),
        .rs2_value_i  (rs2_value_mem),
        .imm_i        (imm_mem),
        .rd_addr_i    (rd_addr_mem),
        .rf_w_en_i    (rf_w_en_mem),
        .mem_w_en_i   (mem_w_en_mem),
        .wbsel_i      (wbsel_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_w_en_o  (dmem_w_en_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .rd_addr_o    (rd_addr_wb),
        .rf_w_en_o    (rf_w_en_wb),
        .rf_wdata_o   (rf_wdata_wb)
    );

    hazard_detect u_hazard_detect (
        .rs1_addr_i    (rs1_addr),
        .rs2_addr_i    (rs2_addr),
        .rs1_used_i    (rs1_used),
        .rs2_used_i    (rs2_used),
        .rd_ex_i       (rd_addr_ex),
        .rf_w_en_ex_i  (rf_w_en_ex),
        .rd_mem_i      (rd_addr_mem),
        .rf_w_en_mem_i (rf_w_en_mem),
        .redirect_i    (redirect),
        .stall_o       (stall),
        .flush_o       (flush_if)
    );

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int PROG_LEN  = 12;

    logic                clk;
    logic                reset_i;
    logic                fill_req;
    logic [31:0]         instr_if;
    logic [31:0]         dmem_rdata;
    logic [31:0]         pc_if;
    logic                dmem_w_en;
    logic [DMEM_AW-1:0]  dmem_addr;
    logic [31:0]         dmem_wdata;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] lcg_state = 32'h5a5e;

    // Test table
    string       test_name   [NUM_TESTS];
    logic [31:0] prog        [NUM_TESTS][PROG_LEN];
    int          store_num   [NUM_TESTS];
    logic [5:0]  exp_addr    [NUM_TESTS];
    logic [31:0] exp_data    [NUM_TESTS];
    logic        forbid_en   [NUM_TESTS];
    logic [5:0]  forbid_addr [NUM_TESTS];

    cpu #(.RESET_PC(32'h0000_0000)) u_cpu (
        .clk          (clk),
        .reset_i      (reset_i),
        .instr_if_i   (instr_if),
        .dmem_rdata_i (dmem_rdata),
        .pc_if_o      (pc_if),
        .dmem_w_en_o  (dmem_w_en),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata)
    );

    always #10 clk = ~clk;

    assign instr_if   = imem[pc_if[7:2]];
    assign dmem_rdata = dmem[dmem_addr];

    // Marker value, distinct per word
    function automatic logic [31:0] fill_value(input logic [5:0] a);
        return {16'hc0de, 4'h0, a, a};
    endfunction

    always @(posedge clk) begin
        if (fill_req) begin
            for (int a = 0; a < 64; a++) begin
                dmem[a] <= fill_value(a[5:0]);
            end
        end else if (dmem_w_en) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] up);
        return {up, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return i_type(OPC_OP_IMM, F3_ADD, rd, rs1, imm);
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic build_table();
        logic [11:0] a;
        logic [11:0] b;
        logic [19:0] up;
        logic [31:0] x1, x3, x4, x5, x6, x7, x8;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                prog[t][i] = NOP_INSTR;
            end
            forbid_en[t]   = 1'b0;
            forbid_addr[t] = 6'd0;
            store_num[t]   = 1;
        end

        // Each ALU op reads the result just produced
        a = 12'(lcg_next() >> 8);
        b = 12'(lcg_next() >> 8);
        x1 = sext12(a);
        x3 = x1 + sext12(b);
        x4 = x1 - x3;
        x5 = x4 ^ x3;
        x6 = x5 & x4;
        x7 = x6 | x1;
        x8 = ($signed(x7) < $signed(x5)) ? 32'd1 : 32'd0;
        test_name[0] = "alu_chain";
        prog[0][0]  = addi(5'd1, 5'd0, a);
        prog[0][1]  = addi(5'd2, 5'd0, b);
        prog[0][2]  = r_type(7'd0, F3_ADD, 5'd3, 5'd1, 5'd2);
        prog[0][3]  = r_type(F7_SUB, F3_ADD, 5'd4, 5'd1, 5'd3);
        prog[0][4]  = r_type(7'd0, F3_XOR, 5'd5, 5'd4, 5'd3);
        prog[0][5]  = r_type(7'd0, F3_AND, 5'd6, 5'd5, 5'd4);
        prog[0][6]  = r_type(7'd0, F3_OR, 5'd7, 5'd6, 5'd1);
        prog[0][7]  = r_type(7'd0, F3_SLT, 5'd8, 5'd7, 5'd5);
        prog[0][8]  = r_type(7'd0, F3_ADD, 5'd9, 5'd8, 5'd7);
        prog[0][9]  = s_type(5'd9, 5'd0, 12'd16);
        prog[0][10] = j_type(5'd0, 21'd0);
        exp_addr[0] = 6'd4;
        exp_data[0] = x8 + x7;

        up = 20'(lcg_next() >> 12);
        a  = 12'(lcg_next() >> 8);
        test_name[1] = "lui_addi";
        prog[1][0] = u_type(5'd1, up);
        prog[1][1] = addi(5'd1, 5'd1, a);
        prog[1][2] = addi(5'd2, 5'd0, 12'd40);
        prog[1][3] = s_type(5'd1, 5'd2, 12'd8);
        prog[1][4] = j_type(5'd0, 21'd0);
        exp_addr[1] = 6'd12;
        exp_data[1] = {up, 12'h000} + sext12(a);

        // Second store holds the sum
        a = 12'(lcg_next() >> 8);
        b = 12'(lcg_next() >> 8);
        test_name[2] = "load_use";
        prog[2][0] = addi(5'd1, 5'd0, a);
        prog[2][1] = addi(5'd2, 5'd0, b);
        prog[2][2] = s_type(5'd1, 5'd0, 12'd20);
        prog[2][3] = i_type(OPC_LOAD, F3_LW, 5'd3, 5'd0, 12'd20);
        prog[2][4] = r_type(7'd0, F3_ADD, 5'd4, 5'd3, 5'd2);
        prog[2][5] = s_type(5'd4, 5'd0, 12'd24);
        prog[2][6] = j_type(5'd0, 21'd0);
        store_num[2] = 2;
        exp_addr[2]  = 6'd6;
        exp_data[2]  = sext12(a) + sext12(b);

        // x4 is only 9 if both fall-through paths ran
        test_name[3] = "branches";
        prog[3][0]  = addi(5'd1, 5'd0, 12'd5);
        prog[3][1]  = addi(5'd2, 5'd0, 12'd5);
        prog[3][2]  = b_type(F3_BNE, 5'd1, 5'd2, 13'd8);
        prog[3][3]  = addi(5'd3, 5'd0, 12'd7);
        prog[3][4]  = b_type(F3_BEQ, 5'd1, 5'd3, 13'd8);
        prog[3][5]  = addi(5'd4, 5'd3, 12'd2);
        prog[3][6]  = b_type(F3_BEQ, 5'd1, 5'd2, 13'd8);
        prog[3][7]  = s_type(5'd4, 5'd0, 12'd36);
        prog[3][8]  = b_type(F3_BNE, 5'd1, 5'd3, 13'd8);
        prog[3][9]  = addi(5'd4, 5'd4, 12'd1);
        prog[3][10] = s_type(5'd4, 5'd0, 12'd40);
        prog[3][11] = j_type(5'd0, 21'd0);
        exp_addr[3]    = 6'd10;
        exp_data[3]    = 32'd7 + 32'd2;
        forbid_en[3]   = 1'b1;
        forbid_addr[3] = 6'd9;

        // Second JAL skips a store that would land after the checked one
        test_name[4] = "jal_link";
        prog[4][0] = addi(5'd2, 5'd0, 12'd4);
        prog[4][1] = j_type(5'd5, 21'd8);
        prog[4][2] = s_type(5'd2, 5'd0, 12'd44);
        prog[4][3] = s_type(5'd5, 5'd0, 12'd48);
        prog[4][4] = j_type(5'd0, 21'd8);
        prog[4][5] = s_type(5'd2, 5'd0, 12'd44);
        prog[4][6] = j_type(5'd0, 21'd0);
        exp_addr[4]    = 6'd12;
        exp_data[4]    = 32'd4 + 32'd4;
        forbid_en[4]   = 1'b1;
        forbid_addr[4] = 6'd11;

        a = 12'((lcg_next() >> 8) | 32'd1);
        test_name[5] = "x0_zero";
        prog[5][0] = addi(5'd0, 5'd0, a);
        prog[5][1] = s_type(5'd0, 5'd0, 12'd52);
        prog[5][2] = j_type(5'd0, 21'd0);
        exp_addr[5] = 6'd13;
        exp_data[5] = 32'd0;
    endtask

    task automatic run_test(input int t);
        int stores;
        @(negedge clk);
        reset_i  = 1'b1;
        fill_req = 1'b1;
        for (int a = 0; a < 64; a++) begin
            imem[a] = (a < PROG_LEN) ? prog[t][a] : NOP_INSTR;
        end
        @(negedge clk);
        fill_req = 1'b0;
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
        check({test_name[t], " reset pc"}, 32'h0000_0000, pc_if);

        stores = 0;
        while (stores < store_num[t]) begin
            @(negedge clk);
            if (dmem_w_en) begin
                stores++;
            end
        end
        check({test_name[t], " address"}, {26'b0, exp_addr[t]}, {26'b0, dmem_addr});
        check({test_name[t], " data"}, exp_data[t], dmem_wdata);

        // Skipped stores must leave the marker in place
        repeat (12) @(negedge clk);
        if (forbid_en[t]) begin
            check({test_name[t], " skipped store"}, fill_value(forbid_addr[t]),
                  dmem[forbid_addr[t]]);
        end
    endtask

    initial begin
        #(NUM_TESTS * 200 * 20);
        $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk      = 1'b0;
        reset_i  = 1'b1;
        fill_req = 1'b0;
        for (int a = 0; a < 64; a++) begin
            imem[a] = NOP_INSTR;
        end
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* src.f */
cpu_pkg.sv
fetch.sv
decode.sv
regfile.sv
execute.sv
memory_access.sv
hazard_detect.sv
cpu.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary
TOP       ?= tb_cpu
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
